// ==== sources.f ====
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
inst_latch.sv
op_classifier.sv
imm_gen.sv
control_merge.sv
rv_decoder.sv
decode_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module decode_tb -f sources.f &&
./obj_dir/Vdecode_tb | tee /dev/stderr | grep -q "All tests passed" ||
{ echo "Simulation did not pass"; exit 1; }

// ==== decode_ref.svh ====
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Galois LFSR stepped once per bit handed out
function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r    = {r[30:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    end
    return r;
endfunction

function automatic ctrl_t idle_ctrl();
    ctrl_t c;
    c          = '0;
    c.alu_op   = ALU_NONE;
    c.lsu_op   = LSU_NONE;
    c.op_a_sel = A_ZERO;
    c.op_b_sel = B_NONE;
    c.pc_sel   = PC_SEQ;
    return c;
endfunction

// Expected control fields from the ISA tables
function automatic ctrl_t decode_ref(input logic [31:0] w);
    alu_op_e    arith[8]  = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                              ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    alu_op_e    branch[8] = '{ALU_BEQ, ALU_BNE, ALU_NONE, ALU_NONE,
                              ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU};
    lsu_op_e    load[8]   = '{LSU_LB, LSU_LH, LSU_LW, LSU_NONE,
                              LSU_LBU, LSU_LHU, LSU_NONE, LSU_NONE};
    ctrl_t      c;
    logic [6:0] opc;
    logic [2:0] f3;
    logic       alt;
    logic       zero7;
    logic       csr;
    logic       ok;
    opc   = w[6:0];
    f3    = w[14:12];
    alt   = (w[31:25] == funct7_alt);
    zero7 = (w[31:25] == 7'd0);
    csr   = (opc == OPC_SYSTEM) && (f3 == 3'd1 || f3 == 3'd2);
    c     = idle_ctrl();
    case (opc)
        OPC_OP:                      ok = zero7 || (alt && (f3 == 3'd0 || f3 == 3'd5));
        OPC_OP_IMM:                  ok = (f3 == 3'd1) ? zero7
                                        : (f3 == 3'd5) ? (zero7 || alt) : 1'b1;
        OPC_LOAD:                    ok = (load[f3] != LSU_NONE);
        OPC_STORE:                   ok = (f3 < 3'd3);
        OPC_BRANCH:                  ok = (branch[f3] != ALU_NONE);
        OPC_JALR:                    ok = (f3 == 3'd0);
        OPC_JAL, OPC_LUI, OPC_AUIPC: ok = 1'b1;
        OPC_SYSTEM:                  ok = csr || w == 32'h0000_0073 || w == 32'h3020_0073;
        default:                     ok = 1'b0;
    endcase
    if (!ok) begin
        c.illegal = 1'b1;
        return c;
    end
    case (opc)
        OPC_OP:     c.alu_op = alt ? ((f3 == 3'd0) ? ALU_SUB : ALU_SRA) : arith[f3];
        OPC_OP_IMM: c.alu_op = (alt && f3 == 3'd5) ? ALU_SRA : arith[f3];
        OPC_BRANCH: c.alu_op = branch[f3];
        OPC_SYSTEM: c.alu_op = !csr ? ALU_NONE : (f3 == 3'd1) ? ALU_CSRRW : ALU_CSRRS;
        default:    c.alu_op = ALU_ADD;
    endcase
    if (opc == OPC_LOAD) begin
        c.lsu_op = load[f3];
    end else if (opc == OPC_STORE) begin
        c.lsu_op = (f3 == 3'd0) ? LSU_SB : (f3 == 3'd1) ? LSU_SH : LSU_SW;
    end
    c.op_a_sel = (csr || opc inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH}) ? A_RS1
               : (opc inside {OPC_AUIPC, OPC_JAL, OPC_JALR}) ? A_PC : A_ZERO;
    c.op_b_sel = (opc inside {OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_LOAD, OPC_STORE}) ? B_IMM
               : (opc inside {OPC_OP, OPC_BRANCH}) ? B_RS2
               : (opc inside {OPC_JAL, OPC_JALR}) ? B_FOUR : B_NONE;
    c.pc_sel   = (opc == OPC_JAL) ? PC_JAL : (opc == OPC_JALR) ? PC_JALR
               : (opc == OPC_BRANCH) ? PC_BRANCH
               : (opc == OPC_SYSTEM && !csr) ? PC_TRAP : PC_SEQ;
    c.rd_wen   = csr || opc inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
                                    OPC_JAL, OPC_JALR, OPC_LOAD};
    c.rs1_used = csr || opc inside {OPC_OP, OPC_OP_IMM, OPC_JALR, OPC_LOAD,
                                    OPC_STORE, OPC_BRANCH};
    c.rs2_used = opc inside {OPC_OP, OPC_STORE, OPC_BRANCH};
    c.csr_wen  = csr;
    c.is_ecall = (w == 32'h0000_0073);
    c.is_mret  = (w == 32'h3020_0073);
    return c;
endfunction

function automatic logic [31:0] expected_imm(input logic [31:0] w);
    case (w[6:0])
        OPC_LUI, OPC_AUIPC: return {w[31:12], 12'h000};
        OPC_JAL:            return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        OPC_STORE:          return 32'($signed({w[31:25], w[11:7]}));
        OPC_BRANCH:         return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        default:            return 32'($signed(w[31:20]));
    endcase
endfunction

function automatic string kind_name(input logic [31:0] w, input ctrl_t c);
    if (c.illegal) begin
        return "illegal";
    end
    case (w[6:0])
        OPC_OP, OPC_OP_IMM:  return "alu";
        OPC_LOAD, OPC_STORE: return "load_store";
        OPC_BRANCH:          return "branch";
        OPC_JAL, OPC_JALR:   return "jump";
        OPC_LUI, OPC_AUIPC:  return "upper_imm";
        default:             return "system";
    endcase
endfunction

// Mostly legal words with random register and immediate bits
function automatic logic [31:0] make_inst();
    opcode_e     opcs[10] = '{OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH,
                              OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC, OPC_SYSTEM};
    logic [31:0] w;
    logic [2:0]  f3;
    logic [6:0]  f7;
    opcode_e     opc;
    int          k;
    w = random_bits(32);
    if (random_bits(3) == 0) begin
        return w;  // Fully random word
    end
    opc = opcs[4'(random_bits(4) % 10)];
    f3  = w[14:12];
    f7  = w[31:25];
    case (opc)
        OPC_OP: begin
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && random_bits(1) == 1) ? funct7_alt : 7'd0;
        end
        OPC_OP_IMM: begin
            if (f3 == 3'd1) begin
                f7 = 7'd0;
            end else if (f3 == 3'd5) begin
                f7 = (random_bits(1) == 1) ? funct7_alt : 7'd0;
            end
        end
        OPC_LOAD: begin
            k  = int'(random_bits(3) % 5);
            f3 = (k < 3) ? 3'(k) : 3'(k + 1);
        end
        OPC_STORE: f3 = 3'(random_bits(2) % 3);
        OPC_BRANCH: begin
            k  = int'(random_bits(3) % 6);
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
        end
        OPC_JALR: f3 = 3'd0;
        OPC_SYSTEM: begin
            k = int'(random_bits(2));
            if (k == 2) begin
                return 32'h0000_0073;  // ECALL
            end else if (k == 3) begin
                return 32'h3020_0073;  // MRET
            end
            f3 = 3'(k + 1);
        end
        default: f3 = w[14:12];
    endcase
    return {f7, w[24:15], f3, w[11:7], opc};
endfunction

`endif

// ==== decode_tb.sv ====
`timescale 1ns/1ns

module decode_tb;
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic                      clock = 1'b0;
    logic                      reset;
    logic                      in_valid;
    logic                      in_ready;
    logic [inst_width-1:0]     inst;
    logic                      out_valid;
    logic                      out_ready;
    ctrl_t                     ctrl;
    reg_idx_t                  rd;
    reg_idx_t                  rs1;
    reg_idx_t                  rs2;
    logic [31:0]               imm;

    logic [31:0]               lfsr = 32'h157b_2339;
    logic [inst_width-1:0]     sent_q[$];    // Accepted but not yet out
    int                        accept_cycle_q[$];
    logic                      timed_q[$];
    string                     phase_q[$];
    int                        cycle = 0;
    int                        checked = 0;
    logic                      in_fire = 1'b0;  // Input handshake at the coming edge
    logic                      stream_on = 1'b0;
    string                     phase = "reset";
    logic                      stall_seen = 1'b0;
    logic [$bits(ctrl_t)+46:0] out_snap = '0;

    `include "decode_ref.svh"

    always #20 clock = ~clock;

    rv_decoder #(.xlen(32)) i_dut (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .inst      (inst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .ctrl      (ctrl),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // Scoreboard and handshake checks
    always @(negedge clock) begin : compare
        logic [inst_width-1:0] w;
        ctrl_t                 exp_ctrl;
        logic [31:0]           exp_imm;
        int                    acc;
        logic                  timed;
        string                 name;
        cycle   = cycle + 1;
        in_fire = in_valid && in_ready && !reset;
        if (!reset) begin
            // Full only with one item in each stage
            assert (sent_q.size() <= 2 && in_ready == (sent_q.size() < 2 || out_ready)) else
                stop_on_error($sformatf("in_ready is %0b with %0d items in flight",
                                        in_ready, sent_q.size()));
            if (stall_seen) begin
                assert (out_valid && {ctrl, rd, rs1, rs2, imm} == out_snap) else
                    stop_on_error("Output changed or dropped while out_ready was low");
            end
            stall_seen = out_valid && !out_ready;
            out_snap   = {ctrl, rd, rs1, rs2, imm};
            if (out_valid && out_ready) begin
                assert (sent_q.size() != 0) else
                    stop_on_error("Output handshake with no instruction in flight");
                w        = sent_q.pop_front();
                acc      = accept_cycle_q.pop_front();
                timed    = timed_q.pop_front();
                exp_ctrl = decode_ref(w);
                exp_imm  = expected_imm(w);
                name     = $sformatf("%s/%s", phase_q.pop_front(), kind_name(w, exp_ctrl));
                assert (ctrl == exp_ctrl) else
                    stop_on_error($sformatf("Mismatch %s ctrl for %h: expected %h, actual %h",
                                            name, w, exp_ctrl, ctrl));
                assert (rd == w[11:7]) else
                    stop_on_error($sformatf("Mismatch %s rd for %h: expected %0d, actual %0d",
                                            name, w, w[11:7], rd));
                assert (rs1 == w[19:15]) else
                    stop_on_error($sformatf("Mismatch %s rs1 for %h: expected %0d, actual %0d",
                                            name, w, w[19:15], rs1));
                assert (rs2 == w[24:20]) else
                    stop_on_error($sformatf("Mismatch %s rs2 for %h: expected %0d, actual %0d",
                                            name, w, w[24:20], rs2));
                assert (imm == exp_imm) else
                    stop_on_error($sformatf("Mismatch %s imm for %h: expected %h, actual %h",
                                            name, w, exp_imm, imm));
                if (timed) begin
                    assert (cycle - acc == 2) else
                        stop_on_error($sformatf(
                            "Mismatch %s latency for %h: expected 2, actual %0d",
                            name, w, cycle - acc));
                end
                checked = checked + 1;
            end
            if (in_fire) begin
                sent_q.push_back(inst);
                accept_cycle_q.push_back(cycle);
                timed_q.push_back(stream_on);
                phase_q.push_back(phase);
            end
        end
    end

    task automatic run_random(input string name, input int cycles, input int ready_weight);
        phase = name;
        for (int n = 0; n < cycles; n++) begin
            @(posedge clock);
            if (in_fire || !in_valid) begin
                in_valid <= (random_bits(2) != 0);
                inst     <= make_inst();
            end
            out_ready <= (int'(random_bits(2)) < ready_weight);  // High ready_weight in 4
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clock);
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        while (sent_q.size() != 0) begin
            @(posedge clock);
            waited = waited + 1;
            if (waited > 20) begin
                stop_on_error("Pipeline did not drain within 20 cycles");
            end
        end
    endtask

    // Back-to-back input with the output always ready
    task automatic stream(input int cycles);
        phase = "throughput";
        @(posedge clock);
        stream_on = 1'b1;
        in_valid  <= 1'b1;
        out_ready <= 1'b1;
        inst      <= make_inst();
        for (int n = 0; n < cycles; n++) begin
            @(posedge clock);
            if (in_fire) begin
                inst <= make_inst();
            end
        end
        in_valid  <= 1'b0;
        stream_on = 1'b0;
    endtask

    initial begin
        reset     <= 1'b1;
        in_valid  <= 1'b0;
        inst      <= '0;
        out_ready <= 1'b0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        assert (!out_valid && in_ready) else
            stop_on_error("After reset out_valid is not low or in_ready is not high");
        run_random("mixed", 800, 3);
        run_random("backpressure", 800, 1);
        drain();
        stream(300);
        drain();
        if (checked >= 600) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Only %0d instructions came out of the decoder", checked);
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule

// ==== rv_decoder.sv ====
`timescale 1ns/1ns

module rv_decoder #(
    parameter int xlen = 32
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  logic [isa_pkg::inst_width-1:0] inst,
    output logic                           out_valid,
    input  logic                           out_ready,
    output ctrl_pkg::ctrl_t                ctrl,
    output ctrl_pkg::reg_idx_t             rd,
    output ctrl_pkg::reg_idx_t             rs1,
    output ctrl_pkg::reg_idx_t             rs2,
    output logic [xlen-1:0]                imm
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic                  held_valid;
    logic [inst_width-1:0] held_inst;
    logic                  take;
    ctrl_t                 dec_ctrl;
    logic [xlen-1:0]       imm_raw;

    inst_latch i_latch (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .inst       (inst),
        .take       (take),
        .held_valid (held_valid),
        .held_inst  (held_inst)
    );

    // Both decoders look at the same held word
    op_classifier i_classifier (
        .held_inst (held_inst),
        .ctrl      (dec_ctrl)
    );

    imm_gen #(.xlen(xlen)) i_imm_gen (
        .held_inst (held_inst),
        .imm_raw   (imm_raw)
    );

    control_merge #(.xlen(xlen)) i_merge (
        .clock      (clock),
        .reset      (reset),
        .held_valid (held_valid),
        .held_inst  (held_inst),
        .ctrl_in    (dec_ctrl),
        .imm_raw    (imm_raw),
        .take       (take),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .ctrl       (ctrl),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .imm        (imm)
    );

endmodule

// ==== control_merge.sv ====
`timescale 1ns/1ns

module control_merge #(
    parameter int xlen = 32
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           held_valid,
    input  logic [isa_pkg::inst_width-1:0] held_inst,
    input  ctrl_pkg::ctrl_t                ctrl_in,
    input  logic [xlen-1:0]                imm_raw,
    output logic                           take,
    output logic                           out_valid,
    input  logic                           out_ready,
    output ctrl_pkg::ctrl_t                ctrl,
    output ctrl_pkg::reg_idx_t             rd,
    output ctrl_pkg::reg_idx_t             rs1,
    output ctrl_pkg::reg_idx_t             rs2,
    output logic [xlen-1:0]                imm
);
    import ctrl_pkg::*;

    reg_idx_t rd_field;
    reg_idx_t rs1_field;
    reg_idx_t rs2_field;

    // Raw field positions whatever the format
    assign rd_field  = held_inst[11:7];
    assign rs1_field = held_inst[19:15];
    assign rs2_field = held_inst[24:20];

    // Load when empty or when the current item leaves this edge
    assign take = held_valid && (!out_valid || out_ready);

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            ctrl <= ctrl_in;
            rd   <= rd_field;
            rs1  <= rs1_field;
            rs2  <= rs2_field;
            imm  <= imm_raw;
        end
    end

endmodule

// ==== imm_gen.sv ====
`timescale 1ns/1ns

module imm_gen #(
    parameter int xlen = 32
) (
    input  logic [isa_pkg::inst_width-1:0] held_inst,
    output logic [xlen-1:0]                imm_raw
);
    import isa_pkg::*;

    opcode_e                      opcode;
    imm_fmt_e                     fmt;
    logic signed [inst_width-1:0] imm_word;

    assign opcode = opcode_e'(held_inst[6:0]);

    // Format depends on the opcode only
    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: fmt = FMT_U;
            OPC_JAL:            fmt = FMT_J;
            OPC_STORE:          fmt = FMT_S;
            OPC_BRANCH:         fmt = FMT_B;
            default:            fmt = FMT_I;
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_S: begin
                imm_word = {{20{held_inst[31]}}, held_inst[31:25], held_inst[11:7]};
            end
            FMT_B: begin
                imm_word = {{20{held_inst[31]}}, held_inst[7], held_inst[30:25],
                            held_inst[11:8], 1'b0};
            end
            FMT_U: begin
                imm_word = {held_inst[31:12], 12'b0};
            end
            FMT_J: begin
                imm_word = {{12{held_inst[31]}}, held_inst[19:12], held_inst[20],
                            held_inst[30:21], 1'b0};
            end
            default: begin
                imm_word = {{20{held_inst[31]}}, held_inst[31:20]};
            end
        endcase
    end

    // Signed cast widens with the sign bit
    assign imm_raw = xlen'(imm_word);

endmodule

// ==== op_classifier.sv ====
`timescale 1ns/1ns

module op_classifier (
    input  logic [isa_pkg::inst_width-1:0] held_inst,
    output ctrl_pkg::ctrl_t                ctrl
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam ctrl_t ctrl_none = '{
        alu_op:   ALU_NONE,
        lsu_op:   LSU_NONE,
        op_a_sel: A_ZERO,
        op_b_sel: B_NONE,
        pc_sel:   PC_SEQ,
        rd_wen:   1'b0,
        rs1_used: 1'b0,
        rs2_used: 1'b0,
        csr_wen:  1'b0,
        is_ecall: 1'b0,
        is_mret:  1'b0,
        illegal:  1'b0
    };

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       f7_zero;
    logic       f7_alt;
    logic       is_ecall_enc;
    logic       is_mret_enc;
    ctrl_t      dec;
    logic       bad;

    assign opcode  = opcode_e'(held_inst[6:0]);
    assign funct3  = held_inst[14:12];
    assign f7_zero = (held_inst[31:25] == funct7_base);
    assign f7_alt  = (held_inst[31:25] == funct7_alt);

    // Privileged forms need every other field zero
    assign is_ecall_enc = (held_inst[31:7] == '0);
    assign is_mret_enc  = (held_inst[31:20] == {funct7_mret, rs2_mret})
                          && (held_inst[19:15] == '0) && (held_inst[11:7] == '0);

    // Shared by register and immediate forms
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        dec = ctrl_none;
        bad = 1'b0;
        case (opcode)
            OPC_OP: begin
                // Alternate funct7 only for SUB and SRA
                bad = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
                dec.alu_op   = arith_op(funct3, f7_alt);
                dec.op_a_sel = A_RS1;
                dec.op_b_sel = B_RS2;
                dec.rd_wen   = 1'b1;
                dec.rs1_used = 1'b1;
                dec.rs2_used = 1'b1;
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b001) begin
                    bad = !f7_zero;                 // SLLI
                end else if (funct3 == 3'b101) begin
                    bad = !(f7_zero || f7_alt);     // SRLI / SRAI
                end
                dec.alu_op   = arith_op(funct3, f7_alt && funct3 == 3'b101);
                dec.op_a_sel = A_RS1;
                dec.op_b_sel = B_IMM;
                dec.rd_wen   = 1'b1;
                dec.rs1_used = 1'b1;
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  dec.lsu_op = LSU_LB;
                    3'b001:  dec.lsu_op = LSU_LH;
                    3'b010:  dec.lsu_op = LSU_LW;
                    3'b100:  dec.lsu_op = LSU_LBU;
                    3'b101:  dec.lsu_op = LSU_LHU;
                    default: bad = 1'b1;
                endcase
                dec.alu_op   = ALU_ADD;             // Address calc
                dec.op_a_sel = A_RS1;
                dec.op_b_sel = B_IMM;
                dec.rd_wen   = 1'b1;
                dec.rs1_used = 1'b1;
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  dec.lsu_op = LSU_SB;
                    3'b001:  dec.lsu_op = LSU_SH;
                    3'b010:  dec.lsu_op = LSU_SW;
                    default: bad = 1'b1;
                endcase
                dec.alu_op   = ALU_ADD;
                dec.op_a_sel = A_RS1;
                dec.op_b_sel = B_IMM;
                dec.rs1_used = 1'b1;
                dec.rs2_used = 1'b1;
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  dec.alu_op = ALU_BEQ;
                    3'b001:  dec.alu_op = ALU_BNE;
                    3'b100:  dec.alu_op = ALU_BLT;
                    3'b101:  dec.alu_op = ALU_BGE;
                    3'b110:  dec.alu_op = ALU_BLTU;
                    3'b111:  dec.alu_op = ALU_BGEU;
                    default: bad = 1'b1;
                endcase
                dec.op_a_sel = A_RS1;
                dec.op_b_sel = B_RS2;
                dec.pc_sel   = PC_BRANCH;
                dec.rs1_used = 1'b1;
                dec.rs2_used = 1'b1;
            end
            OPC_JAL: begin
                dec.alu_op   = ALU_ADD;             // Link value pc + 4
                dec.op_a_sel = A_PC;
                dec.op_b_sel = B_FOUR;
                dec.pc_sel   = PC_JAL;
                dec.rd_wen   = 1'b1;
            end
            OPC_JALR: begin
                bad = (funct3 != 3'b000);
                dec.alu_op   = ALU_ADD;
                dec.op_a_sel = A_PC;
                dec.op_b_sel = B_FOUR;
                dec.pc_sel   = PC_JALR;
                dec.rd_wen   = 1'b1;
                dec.rs1_used = 1'b1;
            end
            OPC_LUI: begin
                dec.alu_op   = ALU_ADD;             // 0 + imm
                dec.op_b_sel = B_IMM;
                dec.rd_wen   = 1'b1;
            end
            OPC_AUIPC: begin
                dec.alu_op   = ALU_ADD;
                dec.op_a_sel = A_PC;
                dec.op_b_sel = B_IMM;
                dec.rd_wen   = 1'b1;
            end
            OPC_SYSTEM: begin
                case (funct3)
                    funct3_csrrw, funct3_csrrs: begin
                        dec.alu_op   = (funct3 == funct3_csrrw) ? ALU_CSRRW : ALU_CSRRS;
                        dec.op_a_sel = A_RS1;
                        dec.rd_wen   = 1'b1;
                        dec.rs1_used = 1'b1;
                        dec.csr_wen  = 1'b1;
                    end
                    funct3_priv: begin
                        dec.pc_sel   = PC_TRAP;
                        dec.is_ecall = is_ecall_enc;
                        dec.is_mret  = is_mret_enc;
                        bad = !(is_ecall_enc || is_mret_enc);   // EBREAK lands here
                    end
                    default: bad = 1'b1;
                endcase
            end
            default: bad = 1'b1;
        endcase

        // Illegal words leave only the flag set
        if (bad) begin
            ctrl         = ctrl_none;
            ctrl.illegal = 1'b1;
        end else begin
            ctrl = dec;
        end
    end

endmodule

// ==== inst_latch.sv ====
`timescale 1ns/1ns

module inst_latch (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  logic [isa_pkg::inst_width-1:0] inst,
    input  logic                           take,
    output logic                           held_valid,
    output logic [isa_pkg::inst_width-1:0] held_inst
);
    import isa_pkg::*;

    logic                  accept;
    logic [inst_width-1:0] inst_q;

    // Free when empty, or when the merge stage drains us this edge
    assign in_ready = !held_valid || take;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (accept) begin
            held_valid <= 1'b1;
        end else if (take) begin
            held_valid <= 1'b0;
        end
    end

    // Accepted instruction word
    always_ff @(posedge clock) begin
        if (accept) begin
            inst_q <= inst;
        end
    end

    assign held_inst = inst_q;

endmodule

// ==== ctrl_pkg.sv ====
package ctrl_pkg;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_CSRRW,
        ALU_CSRRS,
        ALU_NONE = 5'd31
    } alu_op_e;

    typedef enum logic [3:0] {
        LSU_LB,
        LSU_LH,
        LSU_LW,
        LSU_LBU,
        LSU_LHU,
        LSU_SB,
        LSU_SH,
        LSU_SW,
        LSU_NONE
    } lsu_op_e;

    typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} op_a_sel_e;

    typedef enum logic [1:0] {B_IMM, B_RS2, B_FOUR, B_NONE} op_b_sel_e;

    // Next-PC source
    typedef enum logic [2:0] {PC_SEQ, PC_JAL, PC_JALR, PC_BRANCH, PC_TRAP} pc_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        lsu_op_e   lsu_op;
        op_a_sel_e op_a_sel;
        op_b_sel_e op_b_sel;
        pc_sel_e   pc_sel;
        logic      rd_wen;
        logic      rs1_used;
        logic      rs2_used;
        logic      csr_wen;
        logic      is_ecall;
        logic      is_mret;
        logic      illegal;
    } ctrl_t;

    typedef logic [4:0] reg_idx_t;

endpackage

// ==== isa_pkg.sv ====
package isa_pkg;

    // Base instruction word
    localparam int inst_width = 32;

    // Major opcodes in bits [6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // R-type ALU
        OPC_OP_IMM = 7'b0010011,  // I-type ALU
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_SYSTEM = 7'b1110011   // CSR and privileged
    } opcode_e;

    // Immediate layouts
    typedef enum logic [2:0] {
        FMT_I = 3'd0,
        FMT_S = 3'd1,
        FMT_B = 3'd2,
        FMT_U = 3'd3,
        FMT_J = 3'd4
    } imm_fmt_e;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;  // SUB, SRA, SRAI
    localparam logic [6:0] funct7_mret = 7'b0011000;

    // MRET carries 5'b00010 in the rs2 slot
    localparam logic [4:0] rs2_mret = 5'b00010;

    // SYSTEM funct3 values
    localparam logic [2:0] funct3_priv  = 3'b000;  // ECALL, MRET
    localparam logic [2:0] funct3_csrrw = 3'b001;
    localparam logic [2:0] funct3_csrrs = 3'b010;

endpackage
